// File: hw/xbar_bank_arb.sv
`timescale 1ns/1ps
`include "xbar_consts.svh"

// round-robin over channels for one bank, issue is registered
module xbar_bank_arb (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic [`XBAR_NUM_CH-1:0]                 want_i,
  input  xbar_pkg::xbar_addr_t [`XBAR_NUM_CH-1:0] addr_i,
  output logic [`XBAR_NUM_CH-1:0]                 grant_o,
  output logic                                    bank_valid_o,
  output xbar_pkg::xbar_addr_t                    bank_addr_o,
  output xbar_pkg::xbar_ch_t                      bank_ch_o
);
  import xbar_pkg::*;

  xbar_ch_t last_q;  // last granted channel
  xbar_ch_t sel;
  logic     hit;

  // -------------------------------------------------------------------------
  // selection
  // -------------------------------------------------------------------------

  // first wanting channel after last_q, counting up with wrap.
  // reverse order so the smallest offset wins
  always_comb begin
    int cand;

    sel = last_q;
    hit = 1'b0;
    for (int off = `XBAR_NUM_CH; off >= 1; off--) begin
      cand = int'(last_q) + off;
      if (cand >= `XBAR_NUM_CH) begin
        cand = cand - `XBAR_NUM_CH;
      end
      if (want_i[cand]) begin
        sel = xbar_ch_t'(cand);
        hit = 1'b1;
      end
    end
  end

  always_comb begin
    grant_o = '0;
    if (hit) begin
      grant_o[sel] = 1'b1;  // one-hot pulse back to the buffer
    end
  end

  // -------------------------------------------------------------------------
  // issue registers
  // -------------------------------------------------------------------------

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      last_q       <= xbar_ch_t'(`XBAR_NUM_CH - 1);  // ch0 goes first
      bank_valid_o <= 1'b0;
    end else begin
      bank_valid_o <= hit;  // single-cycle strobe
      if (hit) begin
        last_q <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit) begin
      bank_addr_o <= addr_i[sel];
      bank_ch_o   <= sel;
    end
  end

endmodule

// File: hw/xbar_entry_pick.sv
`timescale 1ns/1ps
`include "xbar_consts.svh"

// oldest waiting entry of one channel for one bank
module xbar_entry_pick (
  input  logic [`XBAR_BUF_DEPTH-1:0] valid_i,
  input  xbar_pkg::xbar_idx_t        rd_ptr_i,
  output xbar_pkg::xbar_idx_t        pick_o,
  output logic                       found_o
);
  import xbar_pkg::*;

  // scan from the read pointer forward, wrapping at the depth.
  // the loop runs from the far end back so the nearest hit is the last
  // one written, which keeps the result oldest-first
  always_comb begin
    int slot;

    pick_o  = rd_ptr_i;  // don't care when nothing is found
    found_o = 1'b0;
    for (int i = `XBAR_BUF_DEPTH - 1; i >= 0; i--) begin
      slot = int'(rd_ptr_i) + i;
      if (slot >= `XBAR_BUF_DEPTH) begin
        slot = slot - `XBAR_BUF_DEPTH;  // wrap
      end
      if (valid_i[slot]) begin
        pick_o  = xbar_idx_t'(slot);
        found_o = 1'b1;
      end
    end
  end

endmodule

// File: hw/xbar_pkg.sv
`include "xbar_consts.svh"

package xbar_pkg;

  // -------------------------------------------------------------------------
  // shared vector types
  // -------------------------------------------------------------------------

  // line address, keeps absolute bit numbering so bank bits index directly
  typedef logic [`XBAR_ADDR_MSB:`XBAR_ADDR_LSB] xbar_addr_t;

  typedef logic [`XBAR_BANK_W-1:0] xbar_bank_t;  // bank number

  typedef logic [$clog2(`XBAR_NUM_CH)-1:0] xbar_ch_t;  // channel number

  // slot index into one channel's ring
  typedef logic [$clog2(`XBAR_BUF_DEPTH)-1:0] xbar_idx_t;

  // occupancy 0..depth inclusive
  typedef logic [$clog2(`XBAR_BUF_DEPTH + 1)-1:0] xbar_cnt_t;

endpackage

// File: hw/xbar_req_buffer.sv
`timescale 1ns/1ps
`include "xbar_consts.svh"

// one channel: ring of request slots, per-bank valid arrays, entry picks
module xbar_req_buffer (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  logic                                      req_valid_i,
  input  xbar_pkg::xbar_addr_t                      req_addr_i,
  output logic                                      allow_in_o,
  input  logic [`XBAR_NUM_BANK-1:0]                 grant_i,
  output logic [`XBAR_NUM_BANK-1:0]                 want_o,
  output xbar_pkg::xbar_addr_t [`XBAR_NUM_BANK-1:0] pick_addr_o
);
  import xbar_pkg::*;

  xbar_idx_t  wr_ptr_q;
  xbar_idx_t  rd_ptr_q;
  xbar_cnt_t  used_q;
  xbar_addr_t addr_mem [`XBAR_BUF_DEPTH];  // payload store
  xbar_bank_t req_bank;
  logic       accept;
  logic       free;
  logic [`XBAR_NUM_BANK-1:0] head_vld;     // bank bit of the slot at rd_ptr
  logic [`XBAR_BUF_DEPTH-1:0] wr_dcd;
  xbar_idx_t  pick_idx [`XBAR_NUM_BANK];

  function automatic xbar_idx_t idx_inc(xbar_idx_t p);
    return (p == xbar_idx_t'(`XBAR_BUF_DEPTH - 1)) ? '0 : p + xbar_idx_t'(1);
  endfunction

  function automatic logic [`XBAR_BUF_DEPTH-1:0] slot_dcd(xbar_idx_t p);
    logic [`XBAR_BUF_DEPTH-1:0] v;

    v    = '0;
    v[p] = 1'b1;
    return v;
  endfunction

  // -------------------------------------------------------------------------
  // ring control
  // -------------------------------------------------------------------------

  assign allow_in_o = used_q < xbar_cnt_t'(`XBAR_BUF_DEPTH);
  assign accept     = req_valid_i & allow_in_o;

  // head slot occupied but no bank still holds it
  assign free = (used_q != '0) & ~(|head_vld);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      used_q   <= '0;
    end else begin
      if (accept) begin
        wr_ptr_q <= idx_inc(wr_ptr_q);
      end
      if (free) begin
        rd_ptr_q <= idx_inc(rd_ptr_q);  // at most one slot per cycle
      end
      case ({accept, free})
        2'b10:   used_q <= used_q + xbar_cnt_t'(1);
        2'b01:   used_q <= used_q - xbar_cnt_t'(1);
        default: used_q <= used_q;      // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_mem[wr_ptr_q] <= req_addr_i;
    end
  end

  // bank mapping
  assign req_bank = req_addr_i[`XBAR_BANK_SEL_LSB + 1:`XBAR_BANK_SEL_LSB];
  assign wr_dcd   = slot_dcd(wr_ptr_q);

  // -------------------------------------------------------------------------
  // per-bank valid arrays and picks
  // -------------------------------------------------------------------------

  for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_bank
    logic [`XBAR_BUF_DEPTH-1:0] vld_q;
    logic [`XBAR_BUF_DEPTH-1:0] set_vec;
    logic [`XBAR_BUF_DEPTH-1:0] clr_vec;

    assign set_vec = (accept && req_bank == xbar_bank_t'(b)) ? wr_dcd : '0;
    assign clr_vec = grant_i[b] ? slot_dcd(pick_idx[b]) : '0;  // granted entry

    // set and clear never hit the same slot, the write slot is empty
    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        vld_q <= '0;
      end else begin
        vld_q <= (vld_q & ~clr_vec) | set_vec;
      end
    end

    assign head_vld[b] = vld_q[rd_ptr_q];

    xbar_entry_pick u_pick (
      .valid_i  (vld_q),
      .rd_ptr_i (rd_ptr_q),
      .pick_o   (pick_idx[b]),
      .found_o  (want_o[b])
    );

    assign pick_addr_o[b] = addr_mem[pick_idx[b]];
  end

endmodule

// File: hw/xbar_top.sv
`timescale 1ns/1ps
`include "xbar_consts.svh"

// request side of the cache crossbar, 3 channels into 4 banks
module xbar_top (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic [`XBAR_NUM_CH-1:0]                  ch_req_valid_i,
  input  xbar_pkg::xbar_addr_t [`XBAR_NUM_CH-1:0]  ch_req_addr_i,
  output logic [`XBAR_NUM_CH-1:0]                  ch_req_allow_in_o,
  output logic [`XBAR_NUM_BANK-1:0]                bank_req_valid_o,
  output xbar_pkg::xbar_addr_t [`XBAR_NUM_BANK-1:0] bank_req_addr_o,
  output xbar_pkg::xbar_ch_t [`XBAR_NUM_BANK-1:0]  bank_req_ch_o
);
  import xbar_pkg::*;

  // channel-major, as the buffers see them
  logic [`XBAR_NUM_CH-1:0][`XBAR_NUM_BANK-1:0]       want_cb;
  logic [`XBAR_NUM_CH-1:0][`XBAR_NUM_BANK-1:0]       grant_cb;
  xbar_addr_t [`XBAR_NUM_CH-1:0][`XBAR_NUM_BANK-1:0] addr_cb;

  // bank-major, as the arbiters see them
  logic [`XBAR_NUM_BANK-1:0][`XBAR_NUM_CH-1:0]       want_bc;
  logic [`XBAR_NUM_BANK-1:0][`XBAR_NUM_CH-1:0]       grant_bc;
  xbar_addr_t [`XBAR_NUM_BANK-1:0][`XBAR_NUM_CH-1:0] addr_bc;

  // -------------------------------------------------------------------------
  // channel buffers
  // -------------------------------------------------------------------------

  for (genvar c = 0; c < `XBAR_NUM_CH; c++) begin : g_ch
    xbar_req_buffer u_buf (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (ch_req_valid_i[c]),
      .req_addr_i  (ch_req_addr_i[c]),
      .allow_in_o  (ch_req_allow_in_o[c]),
      .grant_i     (grant_cb[c]),
      .want_o      (want_cb[c]),
      .pick_addr_o (addr_cb[c])
    );
  end

  // transpose between channel order and bank order
  for (genvar c = 0; c < `XBAR_NUM_CH; c++) begin : g_xc
    for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_xb
      assign want_bc[b][c]  = want_cb[c][b];
      assign addr_bc[b][c]  = addr_cb[c][b];
      assign grant_cb[c][b] = grant_bc[b][c];
    end
  end

  // -------------------------------------------------------------------------
  // bank arbiters
  // -------------------------------------------------------------------------

  for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_bk
    xbar_bank_arb u_arb (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .want_i       (want_bc[b]),
      .addr_i       (addr_bc[b]),
      .grant_o      (grant_bc[b]),
      .bank_valid_o (bank_req_valid_o[b]),
      .bank_addr_o  (bank_req_addr_o[b]),
      .bank_ch_o    (bank_req_ch_o[b])
    );
  end

endmodule

// File: include/xbar_consts.svh
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// ---------------------------------------------------------------------------
// crossbar sizing
// ---------------------------------------------------------------------------

`define XBAR_NUM_CH     3  // request channels
`define XBAR_NUM_BANK   4  // cache banks
`define XBAR_BUF_DEPTH  5  // ring slots per channel

// line address, byte offset bits 3:0 are not carried
`define XBAR_ADDR_MSB   31
`define XBAR_ADDR_LSB   4

// bank select is the absolute bit pair 8:7
`define XBAR_BANK_SEL_LSB 7

// ---------------------------------------------------------------------------
// derived widths
// ---------------------------------------------------------------------------

`define XBAR_ADDR_W     (`XBAR_ADDR_MSB - `XBAR_ADDR_LSB + 1)
`define XBAR_BANK_W     $clog2(`XBAR_NUM_BANK)

`endif

// File: list.f
+incdir+include
hw/xbar_pkg.sv
hw/xbar_entry_pick.sv
hw/xbar_req_buffer.sv
hw/xbar_bank_arb.sv
hw/xbar_top.sv
sim/tb_xbar.sv

// File: run.sh
#!/bin/sh
# build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_xbar -f list.f

./obj_dir/Vtb_xbar

// File: sim/tb_xbar.sv
`timescale 1ns/1ps
`include "xbar_consts.svh"

module tb_xbar;
  import xbar_pkg::*;

  localparam int TIMEOUT_CYC = 2000;  // far above the summed test lengths

  logic                              clk_i;
  logic                              rst_i;
  logic [`XBAR_NUM_CH-1:0]           ch_req_valid;
  xbar_addr_t [`XBAR_NUM_CH-1:0]     ch_req_addr;
  logic [`XBAR_NUM_CH-1:0]           ch_req_allow_in;
  logic [`XBAR_NUM_BANK-1:0]         bank_req_valid;
  xbar_addr_t [`XBAR_NUM_BANK-1:0]   bank_req_addr;
  xbar_ch_t [`XBAR_NUM_BANK-1:0]     bank_req_ch;

  // expected addresses per bank and channel
  xbar_addr_t exp_q [`XBAR_NUM_BANK][`XBAR_NUM_CH][$];
  int         issued_ch [`XBAR_NUM_BANK][$];  // channel order seen per bank
  int         acc_cnt [`XBAR_NUM_CH];
  int         iss_cnt [`XBAR_NUM_CH];
  bit         low_seen [`XBAR_NUM_CH];
  bit         rise_seen [`XBAR_NUM_CH];
  bit         occ_check_en;
  int         seed = 91;
  int         cycle_cnt = 0;
  string      test_name = "reset";

  xbar_top u_xbar_top (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .ch_req_valid_i    (ch_req_valid),
    .ch_req_addr_i     (ch_req_addr),
    .ch_req_allow_in_o (ch_req_allow_in),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_addr_o   (bank_req_addr),
    .bank_req_ch_o     (bank_req_ch)
  );

  always #5 clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------

  task automatic stop_run(input string why);
    $display("Checks failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
      stop_run("value mismatch");
    end
  endtask

  // random line address forced onto one bank
  function automatic xbar_addr_t rand_addr(input int bank);
    xbar_addr_t a;

    a = xbar_addr_t'($random(seed));
    a[`XBAR_BANK_SEL_LSB +: 2] = 2'(bank);
    return a;
  endfunction

  function automatic int bank_of(input xbar_addr_t a);
    return int'(a[`XBAR_BANK_SEL_LSB +: 2]);  // bits 8:7
  endfunction

  // ---------------------------------------------------------------------------
  // monitor and timeout
  // ---------------------------------------------------------------------------

  always @(posedge clk_i) begin : monitor
    int c;
    xbar_addr_t head;

    if (!rst_i) begin
      for (int ch = 0; ch < `XBAR_NUM_CH; ch++) begin
        if (occ_check_en) begin  // occupancy is accepted minus issued for in-order traffic
          check({test_name, " allow-in"},
                32'(acc_cnt[ch] - iss_cnt[ch] < `XBAR_BUF_DEPTH),
                32'(ch_req_allow_in[ch]));
        end
        if (!ch_req_allow_in[ch]) begin
          low_seen[ch] = 1'b1;
        end else if (low_seen[ch]) begin
          rise_seen[ch] = 1'b1;
        end
        if (ch_req_valid[ch] && ch_req_allow_in[ch]) begin
          exp_q[bank_of(ch_req_addr[ch])][ch].push_back(ch_req_addr[ch]);
          acc_cnt[ch]++;
        end
      end
      for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
        if (bank_req_valid[b]) begin
          c = int'(bank_req_ch[b]);
          if (c >= `XBAR_NUM_CH) begin
            stop_run("bank strobe carries a channel number out of range");
          end else if (exp_q[b][c].size() == 0) begin
            stop_run("bank strobe without an outstanding request");
          end else begin
            head = exp_q[b][c].pop_front();
            check({test_name, " address"}, 32'(head), 32'(bank_req_addr[b]));
            issued_ch[b].push_back(c);
            iss_cnt[c]++;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      stop_run("timeout, the run went past its cycle limit");
    end
  end

  task automatic wait_strobe(input int b, output int waited);
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > 20) begin
        stop_run("no bank strobe arrived");
      end
    end while (!bank_req_valid[b]);
  endtask

  // banks quiet for several cycles means the buffers have drained
  task automatic wait_drain();
    int waited;
    int quiet;

    waited = 0;
    quiet  = 0;
    while (quiet < 8) begin
      @(negedge clk_i);
      if (|bank_req_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      waited++;
      if (waited > 300) begin
        stop_run("bank strobes never stopped, the buffers did not drain");
      end
    end
    for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
      for (int c = 0; c < `XBAR_NUM_CH; c++) begin
        check({test_name, " queue empty"}, 32'(0), 32'(exp_q[b][c].size()));
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------

  task automatic test_reset();
    test_name = "reset";
    @(negedge clk_i);
    check({test_name, " bank valid"}, 32'(0), 32'(bank_req_valid));
    check({test_name, " allow-in"}, 32'(3'b111), 32'(ch_req_allow_in));
  endtask

  // channel c sends one request to bank c alone
  task automatic test_single();
    xbar_addr_t a;
    int waited;

    test_name = "single";
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      a = rand_addr(c);
      @(posedge clk_i);
      ch_req_valid[c] <= 1'b1;
      ch_req_addr[c]  <= a;
      @(posedge clk_i);  // accepting edge
      check({test_name, " allow-in"}, 32'(1), 32'(ch_req_allow_in[c]));
      ch_req_valid[c] <= 1'b0;
      wait_strobe(c, waited);
      check({test_name, " latency"}, 32'(2), 32'(waited));
      check({test_name, " address"}, 32'(a), 32'(bank_req_addr[c]));
      check({test_name, " channel"}, 32'(c), 32'(bank_req_ch[c]));
    end
  endtask

  // bank 3 still holds its reset grant state here
  task automatic test_round_robin();
    int exp_ch;
    int waited;

    test_name = "round_robin";
    issued_ch[3].delete();
    for (int r = 0; r < 3; r++) begin
      @(posedge clk_i);
      for (int c = 0; c < `XBAR_NUM_CH; c++) begin
        ch_req_valid[c] <= 1'b1;
        ch_req_addr[c]  <= rand_addr(3);
      end
    end
    @(posedge clk_i);
    ch_req_valid <= '0;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > 50) begin
        stop_run("round-robin requests were not all issued");
      end
    end while (issued_ch[3].size() < 9);
    exp_ch = `XBAR_NUM_CH - 1;
    for (int i = 0; i < 9; i++) begin
      exp_ch = (exp_ch + 1) % `XBAR_NUM_CH;  // every channel keeps wanting
      check({test_name, " channel"}, 32'(exp_ch), 32'(issued_ch[3][i]));
    end
  endtask

  task automatic test_flood();
    test_name = "flood";
    for (int k = 0; k < 30; k++) begin
      @(posedge clk_i);
      for (int c = 0; c < `XBAR_NUM_CH; c++) begin
        ch_req_valid[c] <= 1'b1;
        ch_req_addr[c]  <= rand_addr(1);  // refused ones just get replaced
      end
    end
    @(posedge clk_i);
    ch_req_valid <= '0;
    wait_drain();
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      check({test_name, " allow-in dropped"}, 32'(1), 32'(low_seen[c]));
      check({test_name, " allow-in rose"}, 32'(1), 32'(rise_seen[c]));
    end
  endtask

  task automatic test_mixed();
    test_name = "mixed";
    occ_check_en = 1'b0;  // out-of-order grants delay the free
    for (int k = 0; k < 40; k++) begin
      @(posedge clk_i);
      ch_req_valid[1] <= 1'b1;
      ch_req_addr[1]  <= rand_addr($random(seed) & 3);
    end
    @(posedge clk_i);
    ch_req_valid <= '0;
    wait_drain();
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    ch_req_valid = '0;
    ch_req_addr  = '0;
    occ_check_en = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    test_reset();
    test_single();
    test_round_robin();
    test_flood();
    test_mixed();
    $display("All checks passed");
    $finish;
  end

endmodule
